// File: sa_pkg.sv
package sa_pkg;

    // Operand and accumulator widths
    localparam int DATA_WIDTH = 8;
    localparam int PSUM_WIDTH = 2 * DATA_WIDTH;

    typedef logic [PSUM_WIDTH-1:0] psum_t;

    // Multiplier decode modes
    typedef enum logic [1:0] {
        MODE_INT8   = 2'd0,
        MODE_INT4X2 = 2'd1,
        MODE_INT2X4 = 2'd2,
        MODE_SINT8  = 2'd3
    } mode_e;

    // One operand word seen as a single byte, two nibbles or four crumbs
    typedef union packed {
        logic [DATA_WIDTH-1:0]           full;
        logic [1:0][DATA_WIDTH/2-1:0]    nib;
        logic [3:0][DATA_WIDTH/4-1:0]    crumb;
    } operand_u;

    // Array-wide control, one copy fanned out to every PE
    typedef struct packed {
        logic clear;
        logic load_out;
        logic shift;
    } drain_ctrl_s;

endpackage

// File: mfu.sv
module mfu (
    input  sa_pkg::operand_u i_a,
    input  sa_pkg::operand_u i_b,
    input  sa_pkg::mode_e    i_mode,
    output sa_pkg::psum_t    o_p
);
    import sa_pkg::*;

    // Lane products for the packed modes
    logic [1:0][7:0] nib_prod;
    logic [3:0][3:0] crumb_prod;
    logic [8:0]      nib_sum;
    logic [5:0]      crumb_sum;
    psum_t           full_u;
    psum_t           full_s;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            nib_prod[i] = 8'(i_a.nib[i]) * 8'(i_b.nib[i]);
        end
        for (int i = 0; i < 4; i++) begin
            crumb_prod[i] = 4'(i_a.crumb[i]) * 4'(i_b.crumb[i]);
        end
    end

    assign nib_sum   = 9'(nib_prod[0]) + 9'(nib_prod[1]);
    assign crumb_sum = 6'(crumb_prod[0]) + 6'(crumb_prod[1])
                     + 6'(crumb_prod[2]) + 6'(crumb_prod[3]);

    // Full byte, zero-extended or sign-extended before the multiply
    assign full_u = PSUM_WIDTH'(i_a.full) * PSUM_WIDTH'(i_b.full);
    assign full_s = PSUM_WIDTH'(signed'(i_a.full)) * PSUM_WIDTH'(signed'(i_b.full));

    always_comb begin
        case (i_mode)
            MODE_INT8:   o_p = full_u;
            MODE_INT4X2: o_p = psum_t'(nib_sum);
            MODE_INT2X4: o_p = psum_t'(crumb_sum);
            MODE_SINT8:  o_p = full_s;
            default:     o_p = '0;
        endcase
    end

    // No clock here, so the check runs on every change of the mode
    always_comb begin
        assert (!$isunknown(i_mode))
            else $error("mfu: mode is unknown");
    end

endmodule

// File: skew_feeder.sv
module skew_feeder #(
    parameter int ROWS = 2,
    parameter int COLS = 2
) (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_valid,
    input  sa_pkg::operand_u [ROWS-1:0]  i_ifmap,
    input  sa_pkg::operand_u [COLS-1:0]  i_weight,
    output sa_pkg::operand_u [ROWS-1:0]  o_row_ifmap,
    output logic             [ROWS-1:0]  o_row_valid,
    output sa_pkg::operand_u [COLS-1:0]  o_col_weight
);
    import sa_pkg::*;

    // Row r waits r cycles, its valid travels with it
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        if (r == 0) begin : g_pass
            assign o_row_ifmap[r] = i_ifmap[r];
            assign o_row_valid[r] = i_valid;
        end else begin : g_dly
            operand_u [r-1:0] data_q;
            logic     [r-1:0] vld_q;

            always_ff @(posedge i_clk or negedge i_nrst) begin
                if (!i_nrst) begin
                    data_q <= '0;
                    vld_q  <= '0;
                end else begin
                    data_q[0] <= i_ifmap[r];
                    vld_q[0]  <= i_valid;
                    for (int i = 1; i < r; i++) begin
                        data_q[i] <= data_q[i-1];
                        vld_q[i]  <= vld_q[i-1];
                    end
                end
            end

            assign o_row_ifmap[r] = data_q[r-1];
            assign o_row_valid[r] = vld_q[r-1];
        end
    end

    // Column c waits c cycles; the PE enable comes from the row side
    for (genvar c = 0; c < COLS; c++) begin : g_col
        if (c == 0) begin : g_pass
            assign o_col_weight[c] = i_weight[c];
        end else begin : g_dly
            operand_u [c-1:0] data_q;

            always_ff @(posedge i_clk or negedge i_nrst) begin
                if (!i_nrst) begin
                    data_q <= '0;
                end else begin
                    data_q[0] <= i_weight[c];
                    for (int i = 1; i < c; i++) begin
                        data_q[i] <= data_q[i-1];
                    end
                end
            end

            assign o_col_weight[c] = data_q[c-1];
        end
    end

endmodule

// File: pe.sv
module pe (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  sa_pkg::mode_e       i_mode,
    input  sa_pkg::operand_u    i_ifmap,
    input  sa_pkg::operand_u    i_weight,
    input  sa_pkg::psum_t       i_psum,
    input  logic                i_en,
    input  sa_pkg::drain_ctrl_s i_ctrl,
    output sa_pkg::operand_u    o_ifmap,
    output sa_pkg::operand_u    o_weight,
    output sa_pkg::psum_t       o_ofmap
);
    import sa_pkg::*;

    operand_u ifmap_q;
    operand_u weight_q;
    psum_t    acc_q;
    psum_t    out_q;
    psum_t    prod;

    // Product of the operands arriving this cycle
    mfu u_mfu (
        .i_a    (i_ifmap),
        .i_b    (i_weight),
        .i_mode (i_mode),
        .o_p    (prod)
    );

    // Forward ifmap right and weight down, one cycle behind
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            ifmap_q  <= '0;
            weight_q <= '0;
        end else if (i_ctrl.clear) begin
            ifmap_q  <= '0;
            weight_q <= '0;
        end else if (i_en) begin
            ifmap_q  <= i_ifmap;
            weight_q <= i_weight;
        end
    end

    // Output register is either loaded locally or fed from the left neighbour
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            acc_q <= '0;
            out_q <= '0;
        end else if (i_ctrl.load_out) begin
            out_q <= acc_q;
        end else if (i_ctrl.shift) begin
            out_q <= i_psum;
        end else if (i_ctrl.clear) begin
            acc_q <= '0;
            out_q <= '0;
        end else if (i_en) begin
            // Wraps modulo 2^16
            acc_q <= acc_q + prod;
        end
    end

    assign o_ifmap  = ifmap_q;
    assign o_weight = weight_q;
    assign o_ofmap  = out_q;

    // Drain sequencer must never ask for a load and a shift at once
    a_load_shift_excl: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(i_ctrl.load_out && i_ctrl.shift)
    ) else $error("pe: load_out and shift both high");

endmodule

// File: pe_array.sv
module pe_array #(
    parameter int ROWS = 2,
    parameter int COLS = 2
) (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  sa_pkg::mode_e                i_mode,
    input  sa_pkg::operand_u [ROWS-1:0]  i_row_ifmap,
    input  logic             [ROWS-1:0]  i_row_valid,
    input  sa_pkg::operand_u [COLS-1:0]  i_col_weight,
    input  sa_pkg::drain_ctrl_s          i_ctrl,
    output sa_pkg::psum_t    [ROWS-1:0]  o_edge_psum
);
    import sa_pkg::*;

    // Horizontal links carry ifmap and psum, vertical links carry weights
    operand_u ifmap_h  [ROWS][COLS+1];
    operand_u weight_v [ROWS+1][COLS];
    psum_t    psum_h   [ROWS][COLS+1];
    logic     en       [ROWS][COLS];

    for (genvar r = 0; r < ROWS; r++) begin : g_left
        assign ifmap_h[r][0]  = i_row_ifmap[r];
        // Nothing shifts in from the left of column 0
        assign psum_h[r][0]   = '0;
        assign o_edge_psum[r] = psum_h[r][COLS];
    end

    for (genvar c = 0; c < COLS; c++) begin : g_top
        assign weight_v[0][c] = i_col_weight[c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_r
        for (genvar c = 0; c < COLS; c++) begin : g_c
            // Enable follows the row valid, one cycle per column
            if (c == 0) begin : g_en_src
                assign en[r][c] = i_row_valid[r];
            end else begin : g_en_dly
                logic en_q;

                always_ff @(posedge i_clk or negedge i_nrst) begin
                    if (!i_nrst) begin
                        en_q <= 1'b0;
                    end else if (i_ctrl.clear) begin
                        en_q <= 1'b0;
                    end else begin
                        en_q <= en[r][c-1];
                    end
                end

                assign en[r][c] = en_q;
            end

            pe u_pe (
                .i_clk    (i_clk),
                .i_nrst   (i_nrst),
                .i_mode   (i_mode),
                .i_ifmap  (ifmap_h[r][c]),
                .i_weight (weight_v[r][c]),
                .i_psum   (psum_h[r][c]),
                .i_en     (en[r][c]),
                .i_ctrl   (i_ctrl),
                .o_ifmap  (ifmap_h[r][c+1]),
                .o_weight (weight_v[r+1][c]),
                .o_ofmap  (psum_h[r][c+1])
            );
        end
    end

endmodule

// File: drain_unit.sv
module drain_unit #(
    parameter int ROWS = 2,
    parameter int COLS = 2
) (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_drain,
    input  logic                       i_clear,
    input  sa_pkg::psum_t [ROWS-1:0]   i_edge_psum,
    output sa_pkg::drain_ctrl_s        o_ctrl,
    output logic                       o_res_valid,
    output logic [$clog2(COLS)-1:0]    o_res_col,
    output sa_pkg::psum_t [ROWS-1:0]   o_res_data,
    output logic                       o_busy
);
    localparam int              COL_W    = $clog2(COLS);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(COLS - 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_LOAD = 2'd1;
    localparam logic [1:0] ST_EMIT = 2'd2;

    logic [1:0]       state_q;
    logic [COL_W-1:0] col_q;

    // Rightmost column comes out first, so count down
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ST_IDLE;
            col_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_drain) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    state_q <= ST_EMIT;
                    col_q   <= LAST_COL;
                end
                ST_EMIT: begin
                    if (col_q == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        col_q <= col_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign o_ctrl.clear    = i_clear;
    assign o_ctrl.load_out = (state_q == ST_LOAD);
    // Column 0 is the last one out, no shift needed after it
    assign o_ctrl.shift    = (state_q == ST_EMIT) && (col_q != '0);

    assign o_res_valid = (state_q == ST_EMIT);
    assign o_res_col   = col_q;
    assign o_res_data  = i_edge_psum;
    assign o_busy      = (state_q != ST_IDLE);

    // Every shift hands the next lower column to the edge one cycle later
    a_shift_next_col: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_ctrl.shift |=> o_res_valid && (o_res_col == $past(o_res_col) - 1'b1)
    ) else $error("drain_unit: shift not followed by the next lower column");

endmodule

// File: sa_top.sv
module sa_top #(
    parameter int ROWS = 2,
    parameter int COLS = 2
) (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  sa_pkg::mode_e                i_mode,
    input  logic                         i_valid,
    input  sa_pkg::operand_u [ROWS-1:0]  i_ifmap,
    input  sa_pkg::operand_u [COLS-1:0]  i_weight,
    input  logic                         i_clear,
    input  logic                         i_drain,
    output logic                         o_res_valid,
    output logic [$clog2(COLS)-1:0]      o_res_col,
    output sa_pkg::psum_t    [ROWS-1:0]  o_res_data,
    output logic                         o_busy
);
    import sa_pkg::*;

    operand_u [ROWS-1:0] row_ifmap;
    logic     [ROWS-1:0] row_valid;
    operand_u [COLS-1:0] col_weight;
    psum_t    [ROWS-1:0] edge_psum;
    drain_ctrl_s         ctrl;

    // Stagger operands so each PE sees matching pairs
    skew_feeder #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_feeder (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_valid      (i_valid),
        .i_ifmap      (i_ifmap),
        .i_weight     (i_weight),
        .o_row_ifmap  (row_ifmap),
        .o_row_valid  (row_valid),
        .o_col_weight (col_weight)
    );

    pe_array #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_array (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_mode       (i_mode),
        .i_row_ifmap  (row_ifmap),
        .i_row_valid  (row_valid),
        .i_col_weight (col_weight),
        .i_ctrl       (ctrl),
        .o_edge_psum  (edge_psum)
    );

    // Sequences load and shift, labels each column as it leaves
    drain_unit #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_drain (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_drain     (i_drain),
        .i_clear     (i_clear),
        .i_edge_psum (edge_psum),
        .o_ctrl      (ctrl),
        .o_res_valid (o_res_valid),
        .o_res_col   (o_res_col),
        .o_res_data  (o_res_data),
        .o_busy      (o_busy)
    );

endmodule

// File: tb_sa.sv
module tb_sa;
    import sa_pkg::*;

    localparam int ROWS  = 3;
    localparam int COLS  = 4;
    localparam int MAX_K = 12;
    // Test 5 runs two batches, each with at most one bubble per vector
    localparam int LONGEST_K   = 4 * MAX_K;
    localparam int CYCLE_LIMIT = 6 * (LONGEST_K + 2 * COLS + ROWS + 20);

    logic                    i_clk = 1'b0;
    logic                    i_nrst;
    mode_e                   i_mode;
    logic                    i_valid;
    operand_u [ROWS-1:0]     i_ifmap;
    operand_u [COLS-1:0]     i_weight;
    logic                    i_clear;
    logic                    i_drain;
    logic                    o_res_valid;
    logic [$clog2(COLS)-1:0] o_res_col;
    psum_t    [ROWS-1:0]     o_res_data;
    logic                    o_busy;

    // Reference sums, one per PE
    logic [15:0] exp_sum [ROWS][COLS];
    integer      seed;
    int          cur_mode;
    int          test_err;
    int          res_count;
    int          early_err;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    bit          drain_seen;

    sa_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) dut0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_mode      (i_mode),
        .i_valid     (i_valid),
        .i_ifmap     (i_ifmap),
        .i_weight    (i_weight),
        .i_clear     (i_clear),
        .i_drain     (i_drain),
        .o_res_valid (o_res_valid),
        .o_res_col   (o_res_col),
        .o_res_data  (o_res_data),
        .o_busy      (o_busy)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Product of one operand pair under the given mode, wrapped to 16 bits
    function automatic logic [15:0] mode_product(input int mode, input int a, input int b);
        int acc;
        int sa;
        int sb;
        acc = 0;
        sa = (a >= 128) ? a - 256 : a;
        sb = (b >= 128) ? b - 256 : b;
        case (mode)
            0: acc = a * b;
            1: begin
                for (int i = 0; i < 2; i++) begin
                    acc += ((a >> (4 * i)) & 15) * ((b >> (4 * i)) & 15);
                end
            end
            2: begin
                for (int i = 0; i < 4; i++) begin
                    acc += ((a >> (2 * i)) & 3) * ((b >> (2 * i)) & 3);
                end
            end
            default: acc = sa * sb;
        endcase
        return acc[15:0];
    endfunction

    function automatic int random_k();
        return 4 + (($random(seed) & 32'h7fff) % (MAX_K - 3));
    endfunction

    // One input cycle; junk operands ride along with a bubble
    task automatic drive_vector(input bit valid);
        @(posedge i_clk);
        #2;
        i_valid = valid;
        for (int r = 0; r < ROWS; r++) begin
            i_ifmap[r].full = 8'($random(seed));
        end
        for (int c = 0; c < COLS; c++) begin
            i_weight[c].full = 8'($random(seed));
        end
        if (valid) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    exp_sum[r][c] = exp_sum[r][c] + mode_product(cur_mode,
                        int'(i_ifmap[r].full), int'(i_weight[c].full));
                end
            end
        end
    endtask

    task automatic run_batch(input int k);
        int n;
        n = 0;
        while (n < k) begin
            if (($random(seed) & 3) == 0) begin
                drive_vector(1'b0);
            end
            drive_vector(1'b1);
            n++;
        end
        @(posedge i_clk);
        #2;
        i_valid = 1'b0;
    endtask

    // Let earlier valids leave the feeder before the clear lands
    task automatic clear_array(input int m);
        repeat (ROWS + COLS) @(posedge i_clk);
        #2;
        cur_mode = m;
        i_mode   = mode_e'(m);
        i_clear  = 1'b1;
        @(posedge i_clk);
        #2;
        i_clear = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                exp_sum[r][c] = '0;
            end
        end
    endtask

    task automatic drain_and_check(input bit extra_pulse);
        int waited;
        repeat (ROWS + COLS - 1) @(posedge i_clk);
        #2;
        res_count  = 0;
        drain_seen = 1'b1;
        i_drain    = 1'b1;
        @(posedge i_clk);
        #2;
        i_drain = 1'b0;
        waited  = 0;
        while (!o_busy && waited < 4) begin
            @(negedge i_clk);
            waited++;
        end
        assert (o_busy) else begin
            $display("o_busy did not rise after i_drain");
            test_err++;
        end
        // Second request lands mid-burst and must be ignored
        if (extra_pulse) begin
            @(posedge i_clk);
            #2;
            i_drain = 1'b1;
            @(posedge i_clk);
            #2;
            i_drain = 1'b0;
        end
        waited = 0;
        while (o_busy && waited < 2 * COLS + 8) begin
            @(negedge i_clk);
            waited++;
        end
        assert (!o_busy) else begin
            $display("o_busy stayed high after the result burst");
            test_err++;
        end
        repeat (COLS + 4) @(negedge i_clk);
        assert (res_count == COLS) else begin
            $display("Expected %0d results after i_drain but saw %0d", COLS, res_count);
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("Test %s: passed", name);
            pass_cnt++;
        end else begin
            $display("Test %s: failed with %0d errors", name, test_err);
            fail_cnt++;
        end
        test_err = 0;
    endtask

    // Result monitor, sampled mid-cycle
    always @(negedge i_clk) begin : result_monitor
        int exp_col;
        if (!drain_seen) begin
            assert (!o_res_valid && !o_busy) else begin
                $display("o_res_valid or o_busy went high before any drain request");
                early_err++;
            end
        end
        if (o_res_valid) begin
            exp_col = COLS - 1 - res_count;
            if (res_count < COLS) begin
                assert (int'(o_res_col) == exp_col) else begin
                    $display("FAIL o_res_col: got %h, expected %h", o_res_col, exp_col);
                    test_err++;
                end
                for (int r = 0; r < ROWS; r++) begin
                    assert (o_res_data[r] === exp_sum[r][o_res_col]) else begin
                        $display("FAIL o_res_data[%0d] col %0d: got %h, expected %h",
                                 r, o_res_col, o_res_data[r], exp_sum[r][o_res_col]);
                        test_err++;
                    end
                end
            end
            res_count++;
        end
    end

    initial begin
        seed       = 32'h8714;
        cycle_cnt  = 0;
        test_err   = 0;
        res_count  = 0;
        early_err  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        drain_seen = 1'b0;
        cur_mode   = 0;
        i_nrst     = 1'b0;
        i_mode     = MODE_INT8;
        i_valid    = 1'b0;
        i_ifmap    = '0;
        i_weight   = '0;
        i_clear    = 1'b0;
        i_drain    = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                exp_sum[r][c] = '0;
            end
        end
        repeat (5) @(posedge i_clk);
        #2;
        i_nrst = 1'b1;
        repeat (3) @(posedge i_clk);

        // Tests 1 to 4, one per multiplier mode
        for (int m = 0; m < 4; m++) begin
            clear_array(m);
            run_batch(random_k());
            drain_and_check(1'b0);
            finish_test($sformatf("%0d (mode %0d accumulation)", m + 1, m));
        end

        // Accumulators keep running across a drain
        clear_array(0);
        run_batch(random_k());
        drain_and_check(1'b0);
        run_batch(random_k());
        drain_and_check(1'b1);
        finish_test("5 (two batches, drain while busy)");

        // Clear wipes the first batch
        run_batch(random_k());
        clear_array(3);
        run_batch(random_k());
        drain_and_check(1'b0);
        assert (early_err == 0) else begin
            $display("Outputs were active before the first drain request");
            test_err++;
        end
        finish_test("6 (clear between batches, idle after reset)");

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
sa_pkg.sv
mfu.sv
skew_feeder.sv
pe.sv
pe_array.sv
drain_unit.sv
sa_top.sv
tb_sa.sv

// File: Makefile
# Verilator build and run for the systolic array testbench

VERILATOR ?= verilator
TOP       ?= tb_sa
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
